// File: src/uart_pkg.sv
`default_nettype none

package uart_pkg;

   // Register bus and bit timing
   localparam int BUS_WIDTH = 32;
   localparam int CPB_WIDTH = 16;                      // Low bits of CPB register in effect
   localparam logic [BUS_WIDTH-1:0] CPB_RESET = 217;   // 25 MHz clock, 115200 baud

   // Register map
   localparam logic [3:0] REG_DR           = 4'd0;     // Tx data write, last rx byte read
   localparam logic [3:0] REG_CTRL         = 4'd1;
   localparam logic [3:0] REG_RSTAT        = 4'd2;
   localparam logic [3:0] REG_TSTAT        = 4'd3;
   localparam logic [3:0] REG_CPB          = 4'd4;
   localparam logic [3:0] REG_QUEUE        = 4'd5;     // Read pops the receive FIFO
   localparam logic [3:0] REG_SCRATCH_BASE = 4'd12;    // Four words up to 15

   // Control register bits
   localparam int CTRL_RX_EN = 0;
   localparam int CTRL_TX_EN = 1;

   // Receive status bits
   localparam int RSTAT_NOT_EMPTY = 0;
   localparam int RSTAT_BREAK     = 1;
   localparam int RSTAT_FULL      = 2;
   localparam int RSTAT_LAST_LSB  = 8;                 // Last received byte in 15:8
   localparam int RSTAT_COUNT_LSB = 16;                // FIFO fill count from here up

   // Transmit status bits
   localparam int TSTAT_TC = 0;                        // Transmitter idle

endpackage

`default_nettype wire

// File: src/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx
(
   input  wire                            clk,
   input  wire                            reset,
   input  wire [uart_pkg::CPB_WIDTH-1:0]  cycles_per_bit,
   input  wire                            tx_start,
   input  wire [7:0]                      tx_data,
   output logic                           txd,
   output logic                           tx_busy
);
   import uart_pkg::*;

   logic [9:0]           shreg;        // Stop bit, data, start bit
   logic [CPB_WIDTH-1:0] period_cnt;   // Cycles left in current bit
   logic [3:0]           bit_cnt;      // Bits already sent

   // Line is driven straight from the frame register
   assign txd = shreg[0];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         shreg      <= '1;             // Idle line high
         tx_busy    <= 1'b0;
         period_cnt <= '0;
         bit_cnt    <= '0;
      end
      else if (!tx_busy)
      begin
         if (tx_start)
         begin
            shreg      <= {1'b1, tx_data, 1'b0};
            tx_busy    <= 1'b1;
            period_cnt <= cycles_per_bit - 1'b1;
            bit_cnt    <= '0;
         end
      end
      else if (period_cnt != '0)
      begin
         period_cnt <= period_cnt - 1'b1;
      end
      else
      begin
         // Next bit once the period runs out
         shreg      <= {1'b1, shreg[9:1]};   // Fill with ones so idle stays high
         period_cnt <= cycles_per_bit - 1'b1;
         if (bit_cnt == 4'd9)
         begin
            tx_busy <= 1'b0;           // Stop bit done
         end
         else
         begin
            bit_cnt <= bit_cnt + 1'b1;
         end
      end
   end

   // Between frames the line must rest at the mark level
   idle_line_high: assert property (
      @(posedge clk) disable iff (reset)
      !tx_busy |-> txd
   );

endmodule

`default_nettype wire

// File: src/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx
(
   input  wire                            clk,
   input  wire                            reset,
   input  wire [uart_pkg::CPB_WIDTH-1:0]  cycles_per_bit,
   input  wire                            rx_en,
   input  wire                            rxd,
   output logic                           rx_valid,
   output logic [7:0]                     rx_data,
   output logic                           rx_break
);
   import uart_pkg::*;

   localparam logic [2:0] S_IDLE      = 3'd0;
   localparam logic [2:0] S_START     = 3'd1;
   localparam logic [2:0] S_DATA      = 3'd2;
   localparam logic [2:0] S_STOP      = 3'd3;
   localparam logic [2:0] S_FINISH    = 3'd4;
   localparam logic [2:0] S_WAIT_HIGH = 3'd5;

   logic [1:0]           sync;         // Two-flop synchronizer
   logic                 rxd_s;
   logic [2:0]           state;
   logic [CPB_WIDTH-1:0] cnt;
   logic [CPB_WIDTH-1:0] half_bit;
   logic [2:0]           bit_cnt;
   logic [7:0]           shreg;
   logic                 sample_tick;

   assign rxd_s       = sync[1];
   assign half_bit    = cycles_per_bit >> 1;
   assign sample_tick = rx_en && (state == S_DATA) && (cnt == '0);

   always_ff @(posedge clk)
   begin
      if (reset)
         sync <= 2'b11;
      else
         sync <= {sync[0], rxd};
   end

   // Data bits arrive LSB first
   always_ff @(posedge clk)
   begin
      if (sample_tick)
         shreg <= {rxd_s, shreg[7:1]};
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= S_WAIT_HIGH;
         cnt      <= '0;
         bit_cnt  <= '0;
         rx_valid <= 1'b0;
         rx_data  <= '0;
         rx_break <= 1'b0;
      end
      else
      begin
         rx_valid <= 1'b0;
         if (!rx_en)
         begin
            state <= S_WAIT_HIGH;      // Resync on a high line once enabled
         end
         else
         begin
            case (state)
               // Entered only with the line high, so low here is the start edge
               S_IDLE:
                  if (!rxd_s)
                  begin
                     state <= S_START;
                     cnt   <= half_bit - 1'b1;
                  end
               S_START:
                  if (cnt != '0)
                     cnt <= cnt - 1'b1;
                  else if (!rxd_s)
                  begin
                     state   <= S_DATA;    // Start bit confirmed at mid-bit
                     cnt     <= cycles_per_bit - 1'b1;
                     bit_cnt <= '0;
                  end
                  else
                     state <= S_IDLE;      // Glitch
               S_DATA:
                  if (cnt != '0)
                     cnt <= cnt - 1'b1;
                  else
                  begin
                     cnt     <= cycles_per_bit - 1'b1;
                     bit_cnt <= bit_cnt + 1'b1;
                     if (bit_cnt == 3'd7)
                        state <= S_STOP;
                  end
               S_STOP:
                  if (cnt != '0)
                     cnt <= cnt - 1'b1;
                  else if (rxd_s)
                  begin
                     state <= S_FINISH;
                     cnt   <= half_bit - 1'b1;
                  end
                  else
                  begin
                     if (shreg == 8'd0)
                        rx_break <= 1'b1;  // All-zero frame, low stop bit
                     state <= S_WAIT_HIGH;
                  end
               S_FINISH:
                  if (cnt != '0)
                     cnt <= cnt - 1'b1;
                  else
                  begin
                     rx_valid <= 1'b1;
                     rx_data  <= shreg;
                     rx_break <= 1'b0;
                     state    <= S_IDLE;
                  end
               S_WAIT_HIGH:
                  if (rxd_s)
                     state <= S_IDLE;
               default:
                  state <= S_WAIT_HIGH;
            endcase
         end
      end
   end

   single_cycle_valid: assert property (
      @(posedge clk) disable iff (reset)
      rx_valid |=> !rx_valid
   );

endmodule

`default_nettype wire

// File: src/rx_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module rx_fifo
#(
   parameter int DEPTH_LOG2 = 4
)
(
   input  wire                     clk,
   input  wire                     reset,
   input  wire                     wr,
   input  wire [7:0]               din,
   input  wire                     rd,
   output logic [7:0]              dout,
   output logic                    empty,
   output logic                    full,
   output logic [DEPTH_LOG2:0]     count
);

   localparam int DEPTH = 1 << DEPTH_LOG2;

   logic [7:0]            mem [0:DEPTH-1];
   logic [DEPTH_LOG2-1:0] wptr;
   logic [DEPTH_LOG2-1:0] rptr;
   logic                  do_wr;
   logic                  do_rd;

   assign do_wr = wr && !full;         // Drop on overflow
   assign do_rd = rd && !empty;
   assign empty = (count == '0);
   assign full  = (count == (DEPTH_LOG2 + 1)'(DEPTH));
   assign dout  = mem[rptr];           // Head shown without a read strobe

   always_ff @(posedge clk)
   begin
      if (do_wr)
         mem[wptr] <= din;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wptr  <= '0;
         rptr  <= '0;
         count <= '0;
      end
      else
      begin
         if (do_wr)
            wptr <= wptr + 1'b1;
         if (do_rd)
            rptr <= rptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // Both or neither
         endcase
      end
   end

   count_in_range: assert property (
      @(posedge clk) disable iff (reset)
      count <= (DEPTH_LOG2 + 1)'(DEPTH)
   );

endmodule

`default_nettype wire

// File: src/uart.sv
`timescale 1ns/1ns
`default_nettype none

module uart
#(
   parameter int FIFO_DEPTH_LOG2 = 4
)
(
   input  wire                            clk,
   input  wire                            reset,
   input  wire                            cs,
   input  wire                            wen,
   input  wire [3:0]                      addr,
   input  wire [uart_pkg::BUS_WIDTH-1:0]  din,
   output logic [uart_pkg::BUS_WIDTH-1:0] dout,
   input  wire                            rxd,
   output logic                           txd
);
   import uart_pkg::*;

   logic                       bus_wr;
   logic                       bus_rd;
   logic [BUS_WIDTH-1:0]       control;
   logic [BUS_WIDTH-1:0]       cpb_reg;
   logic [BUS_WIDTH-1:0]       scratch [0:3];
   logic                       scratch_sel;
   logic [CPB_WIDTH-1:0]       cycles_per_bit;
   logic                       tx_start;
   logic                       tx_busy;
   logic                       rx_valid;
   logic [7:0]                 rx_data;
   logic                       rx_break;
   logic                       fifo_pop;
   logic [7:0]                 fifo_head;
   logic                       fifo_empty;
   logic                       fifo_full;
   logic [FIFO_DEPTH_LOG2:0]   fifo_count;
   logic [BUS_WIDTH-1:0]       rstat;
   logic [BUS_WIDTH-1:0]       tstat;

   assign bus_wr         = cs && wen;
   assign bus_rd         = cs && !wen;
   assign scratch_sel    = (addr >= REG_SCRATCH_BASE);
   assign cycles_per_bit = cpb_reg[CPB_WIDTH-1:0];

   // Writes while the transmitter is busy are lost
   assign tx_start = bus_wr && (addr == REG_DR) && control[CTRL_TX_EN] && !tx_busy;
   assign fifo_pop = bus_rd && (addr == REG_QUEUE);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         control <= '0;
         cpb_reg <= CPB_RESET;
         for (int i = 0; i < 4; i++)
            scratch[i] <= '0;
      end
      else if (bus_wr)
      begin
         if (addr == REG_CTRL)
            control <= din;
         if (addr == REG_CPB)
            cpb_reg <= din;
         if (scratch_sel)
            scratch[addr[1:0]] <= din;   // Base is 12, low bits index
      end
   end

   uart_tx u_tx (
      .clk            (clk),
      .reset          (reset),
      .cycles_per_bit (cycles_per_bit),
      .tx_start       (tx_start),
      .tx_data        (din[7:0]),
      .txd            (txd),
      .tx_busy        (tx_busy)
   );

   uart_rx u_rx (
      .clk            (clk),
      .reset          (reset),
      .cycles_per_bit (cycles_per_bit),
      .rx_en          (control[CTRL_RX_EN]),
      .rxd            (rxd),
      .rx_valid       (rx_valid),
      .rx_data        (rx_data),
      .rx_break       (rx_break)
   );

   rx_fifo #(
      .DEPTH_LOG2 (FIFO_DEPTH_LOG2)
   ) u_fifo (
      .clk   (clk),
      .reset (reset),
      .wr    (rx_valid),
      .din   (rx_data),
      .rd    (fifo_pop),
      .dout  (fifo_head),
      .empty (fifo_empty),
      .full  (fifo_full),
      .count (fifo_count)
   );

   always_comb
   begin
      rstat = '0;
      rstat[RSTAT_NOT_EMPTY] = !fifo_empty;
      rstat[RSTAT_BREAK]     = rx_break;
      rstat[RSTAT_FULL]      = fifo_full;
      rstat[RSTAT_LAST_LSB +: 8] = rx_data;
      rstat[RSTAT_COUNT_LSB +: FIFO_DEPTH_LOG2 + 1] = fifo_count;
      tstat = '0;
      tstat[TSTAT_TC] = !tx_busy;
   end

   // Read data follows the address in the same cycle
   always_comb
   begin
      dout = '0;
      case (addr)
         REG_DR:    dout = BUS_WIDTH'(rx_data);
         REG_CTRL:  dout = control;
         REG_RSTAT: dout = rstat;
         REG_TSTAT: dout = tstat;
         REG_CPB:   dout = cpb_reg;
         REG_QUEUE: dout = fifo_empty ? '0 : BUS_WIDTH'(fifo_head);  // Hide stale slot
         default:
            if (scratch_sel)
               dout = scratch[addr[1:0]];
      endcase
   end

   dout_known: assert property (
      @(posedge clk) disable iff (reset)
      cs |-> !$isunknown(dout)
   );

   // Popping an empty FIFO must never hand the CPU stale data
   empty_pop_reads_zero: assert property (
      @(posedge clk) disable iff (reset)
      (fifo_pop && fifo_empty) |-> (dout == '0)
   );

endmodule

`default_nettype wire

// File: testbench/tb_uart.sv
`timescale 1ns/1ns
`default_nettype none

module tb_uart;
   import uart_pkg::*;

   localparam int N_TX        = 5;
   localparam int N_RX        = 10;
   localparam int MAX_CPB     = 12;
   // Slots of 12 bit times with three for each tx frame and its idle window
   localparam int FRAME_SLOTS = N_TX * 3 + 1 + N_RX + 17 + 5;
   localparam int CYCLE_LIMIT = FRAME_SLOTS * 12 * MAX_CPB + 4000;

   logic        clk = 1'b0;
   logic        reset;
   logic        cs;
   logic        wen;
   logic [3:0]  addr;
   logic [31:0] din;
   logic [31:0] dout;
   logic        rxd;
   logic        txd;

   logic [31:0] rng_state = 32'h40278d23;
   int          cycles = 0;
   int          errors = 0;
   int          checks = 0;
   int          cpb = 217;
   int          write_cycle;
   int          read_cycle;
   logic [31:0] shadow [0:5];    // CTRL, CPB, then the four scratch words
   logic [7:0]  exp_q [$];
   logic [7:0]  last_exp = 8'h00;
   logic        brk_exp = 1'b0;

   uart #(.FIFO_DEPTH_LOG2(4)) dut (
      .clk   (clk),
      .reset (reset),
      .cs    (cs),
      .wen   (wen),
      .addr  (addr),
      .din   (din),
      .dout  (dout),
      .rxd   (rxd),
      .txd   (txd)
   );

   always #20 clk = ~clk;

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT)
      begin
         $display("Run stopped: cycle limit of %0d reached before the tests ended", CYCLE_LIMIT);
         $display("TB FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] next_random();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic logic [3:0] rw_addr(input int k);
      if (k == 0)
         return REG_CTRL;
      if (k == 1)
         return REG_CPB;
      return REG_SCRATCH_BASE + 4'(k - 2);
   endfunction

   // Receive status as the model sees it
   function automatic logic [31:0] model_rstat();
      logic [31:0] w;
      w = '0;
      w[RSTAT_NOT_EMPTY] = (exp_q.size() != 0);
      w[RSTAT_BREAK] = brk_exp;
      w[RSTAT_FULL] = (exp_q.size() == 16);
      w[RSTAT_LAST_LSB +: 8] = last_exp;
      w[RSTAT_COUNT_LSB +: 5] = 5'(exp_q.size());
      return w;
   endfunction

   task automatic expect_word(input logic [31:0] got, input logic [31:0] exp, input string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Error at %0t ns: %s read %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic bus_write(input logic [3:0] a, input logic [31:0] d);
      @(posedge clk);
      cs   <= 1'b1;
      wen  <= 1'b1;
      addr <= a;
      din  <= d;
      @(posedge clk);
      cs  <= 1'b0;
      wen <= 1'b0;
      write_cycle = cycles + 1;        // Count as seen at the next falling edge
   endtask

   // dout is sampled mid-cycle and the pop lands on the closing edge
   task automatic bus_read(input logic [3:0] a, output logic [31:0] d);
      @(posedge clk);
      cs   <= 1'b1;
      wen  <= 1'b0;
      addr <= a;
      @(negedge clk);
      d = dout;
      read_cycle = cycles;
      @(posedge clk);
      cs <= 1'b0;
   endtask

   task automatic check_reg(input logic [3:0] a, input logic [31:0] exp, input string what);
      logic [31:0] got;
      bus_read(a, got);
      expect_word(got, exp, what);
   endtask

   task automatic wait_rstat();
      logic [31:0] exp;
      logic [31:0] got;
      int          tries;
      exp = model_rstat();
      tries = 0;
      bus_read(REG_RSTAT, got);
      while (got !== exp && tries < 4 * cpb)
      begin
         bus_read(REG_RSTAT, got);
         tries++;
      end
      expect_word(got, exp, "RSTAT");
   endtask

   task automatic send_frame(input logic [7:0] b, input logic stop_bit);
      logic [9:0] frame;
      frame = {stop_bit, b, 1'b0};
      for (int i = 0; i < 10; i++)
      begin
         @(posedge clk);
         rxd <= frame[i];
         repeat (cpb - 1) @(posedge clk);
      end
      @(posedge clk);
      rxd <= 1'b1;
      repeat (2 * cpb - 1) @(posedge clk);   // Covers the receiver's tail after the stop bit
   endtask

   task automatic rx_expect(input logic [7:0] b);
      if (exp_q.size() < 16)
         exp_q.push_back(b);
      last_exp = b;
      brk_exp  = 1'b0;
   endtask

   task automatic pop_and_check();
      logic [31:0] got;
      logic [7:0]  exp;
      exp = exp_q.pop_front();
      bus_read(REG_QUEUE, got);
      expect_word(got, {24'h0, exp}, "QUEUE");
   endtask

   // Line monitor sampling txd in the middle of each bit
   task automatic watch_tx_frame(input logic [7:0] exp);
      logic [7:0] got;
      int         waited;
      waited = 0;
      @(negedge clk);
      while (txd !== 1'b0 && waited < 4 * cpb)
      begin
         @(negedge clk);
         waited++;
      end
      if (txd !== 1'b0)
      begin
         errors++;
         $display("No start bit appeared on txd after the data write");
      end
      else
      begin
         repeat (cpb / 2) @(negedge clk);
         expect_word({31'h0, txd}, 32'h0, "txd start bit");
         for (int i = 0; i < 8; i++)
         begin
            repeat (cpb) @(negedge clk);
            got[i] = txd;
         end
         expect_word({24'h0, got}, {24'h0, exp}, "txd data");
         repeat (cpb) @(negedge clk);
         expect_word({31'h0, txd}, 32'h1, "txd stop bit");
      end
   endtask

   task automatic expect_no_frame(input int n);
      logic seen_low;
      seen_low = 1'b0;
      repeat (n)
      begin
         @(negedge clk);
         if (txd !== 1'b1)
            seen_low = 1'b1;
      end
      expect_word({31'h0, seen_low}, 32'h0, "txd low in idle window");
   endtask

   task automatic wait_tx_done(input int start_cycle);
      logic [31:0] got;
      int          elapsed;
      bus_read(REG_TSTAT, got);
      expect_word(got, 32'h0, "TSTAT during frame");
      while (got[TSTAT_TC] !== 1'b1 && read_cycle - start_cycle < 12 * cpb)
         bus_read(REG_TSTAT, got);
      elapsed = read_cycle - start_cycle;
      checks++;
      if (got[TSTAT_TC] !== 1'b1)
      begin
         errors++;
         $display("Transmitter still busy %0d cycles after the data write", elapsed);
      end
      else if (elapsed < 10 * cpb || elapsed > 10 * cpb + 3)
      begin
         errors++;
         $display("Error at %0t ns: TC set after %0d cycles, expected %0d", $time, elapsed,
                  10 * cpb);
      end
   endtask

   initial
   begin
      logic [31:0] r;
      int          k;
      int          t0;
      cs    <= 1'b0;
      wen   <= 1'b0;
      addr  <= 4'h0;
      din   <= 32'h0;
      rxd   <= 1'b1;
      reset <= 1'b1;
      for (int j = 0; j < 6; j++)
         shadow[j] = 32'h0;
      shadow[1] = 32'd217;
      repeat (10) @(posedge clk);
      reset <= 1'b0;

      check_reg(REG_CTRL, 32'h0, "CTRL after reset");
      check_reg(REG_CPB, 32'd217, "CPB after reset");
      check_reg(REG_TSTAT, 32'h1, "TSTAT after reset");
      check_reg(REG_RSTAT, 32'h0, "RSTAT after reset");

      // Register readback
      for (int n = 0; n < 12; n++)
      begin
         k = int'(next_random() % 32'd6);
         r = next_random();
         bus_write(rw_addr(k), r);
         shadow[k] = r;
         for (int j = 0; j < 6; j++)
            check_reg(rw_addr(j), shadow[j], "register readback");
      end
      for (int j = 6; j < 12; j++)
         check_reg(4'(j), 32'h0, "unmapped address");

      // Transmit with the second write of each pair landing while busy
      cpb = 4 + int'(next_random() % 32'd9);
      bus_write(REG_CPB, 32'(cpb));
      bus_write(REG_CTRL, 32'h3);
      for (int n = 0; n < N_TX; n++)
      begin
         r = next_random();
         bus_write(REG_DR, r);
         t0 = write_cycle;
         fork
            watch_tx_frame(r[7:0]);
            begin
               bus_write(REG_DR, ~r);
               wait_tx_done(t0);
            end
         join
         expect_no_frame(12 * cpb);
      end
      bus_write(REG_CTRL, 32'h1);
      bus_write(REG_DR, next_random());
      expect_no_frame(12 * cpb);
      check_reg(REG_TSTAT, 32'h1, "TSTAT with TX disabled");

      // Receive with random pops in between
      cpb = 4 + int'(next_random() % 32'd9);
      bus_write(REG_CPB, 32'(cpb));
      for (int n = 0; n < N_RX; n++)
      begin
         r = next_random();
         send_frame(r[7:0], 1'b1);
         rx_expect(r[7:0]);
         wait_rstat();
         check_reg(REG_DR, {24'h0, last_exp}, "DR last byte");
         if (r[8])
         begin
            pop_and_check();
            wait_rstat();
         end
      end
      while (exp_q.size() != 0)
         pop_and_check();
      check_reg(REG_QUEUE, 32'h0, "QUEUE when empty");
      wait_rstat();

      // Overflow drops the 17th byte
      for (int n = 0; n < 17; n++)
      begin
         r = next_random();
         send_frame(r[7:0], 1'b1);
         rx_expect(r[7:0]);
         wait_rstat();
      end
      for (int n = 0; n < 16; n++)
         pop_and_check();
      wait_rstat();

      // Break from a zero frame and cleared by a valid one
      send_frame(8'h00, 1'b0);
      brk_exp = 1'b1;
      wait_rstat();
      r = next_random();
      send_frame(r[7:0], 1'b1);
      rx_expect(r[7:0]);
      wait_rstat();
      pop_and_check();
      wait_rstat();

      // Frames with the receiver disabled leave the model as it is
      bus_write(REG_CTRL, 32'h2);
      for (int n = 0; n < 2; n++)
      begin
         r = next_random();
         send_frame(r[7:0], 1'b1);
         wait_rstat();
      end
      bus_write(REG_CTRL, 32'h1);
      r = next_random();
      send_frame(r[7:0], 1'b1);
      rx_expect(r[7:0]);
      wait_rstat();
      pop_and_check();
      wait_rstat();

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: uart_periph.f
src/uart_pkg.sv
src/uart_tx.sv
src/uart_rx.sv
src/rx_fifo.sv
src/uart.sv
testbench/tb_uart.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_uart
FILELIST  = uart_periph.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TB PASSED"

clean:
	rm -rf obj_dir
